// File: source/rob_pkg.sv
package rob_pkg;

    // slots written per allocation
    localparam int group_size = 4;

    // most entries retired in one cycle
    localparam int commit_width = 4;

    // holds 0 to commit_width
    localparam int cnt_w = $clog2(commit_width + 1);

    localparam int preg_w = 6;
    localparam int pc_w = 16;
    localparam int cond_w = 2;

    // a zero compare result means no branch resolves
    localparam int cmp_w = 2;

    localparam int n_done_ports = 4;

    // power of two and a multiple of group_size
    localparam int default_depth = 64;

endpackage

// File: source/rob_pointers.sv
`timescale 1ns/1ps

module rob_pointers #(
    parameter int rob_depth = rob_pkg::default_depth,
    localparam int idx_w = $clog2(rob_depth)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      alloc,
    input  logic [rob_pkg::cnt_w-1:0] cmt_cnt,
    input  logic                      mis_pred,
    input  logic [idx_w-1:0]          mis_pred_idx,
    output logic [idx_w:0]            head,
    output logic [idx_w:0]            tail,
    output logic [idx_w:0]            next_idx,
    output logic                      full_stll,
    output logic                      empt
);
    import rob_pkg::*;

    logic [idx_w:0] occ;
    logic [idx_w:0] br_ptr;
    logic [idx_w:0] rewind_ptr;
    logic           alloc_ok;

    // wrap bit makes tail minus head the occupancy, even when full
    assign occ = tail - head;
    assign full_stll = int'(occ) > rob_depth - group_size;
    assign empt = (occ == '0);

    // allocation always lands on the current tail
    assign next_idx = tail;

    // the rewind wins over a new group
    assign alloc_ok = alloc && !full_stll && !mis_pred;

    // branch pointer with its own wrap bit, from its distance to head
    assign br_ptr = head + {1'b0, mis_pred_idx - head[idx_w-1:0]};

    // first slot of the group after the branch
    assign rewind_ptr = {br_ptr[idx_w:2] + 1'b1, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= head + (idx_w + 1)'(cmt_cnt);
            if (mis_pred) begin
                tail <= rewind_ptr;
            end else if (alloc_ok) begin
                tail <= tail + (idx_w + 1)'(group_size);
            end
        end
    end

endmodule

// File: source/rob_entry_array.sv
`timescale 1ns/1ps

module rob_entry_array #(
    parameter int rob_depth = rob_pkg::default_depth,
    localparam int idx_w = $clog2(rob_depth)
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           alloc,
    input  logic [rob_pkg::group_size-1:0]                 slot_vld,
    input  logic [rob_pkg::group_size-1:0]                 slot_reg_wrt,
    input  logic [rob_pkg::group_size-1:0]                 slot_brnc,
    input  logic [rob_pkg::group_size-1:0]                 slot_pred,
    input  logic [rob_pkg::group_size*rob_pkg::cond_w-1:0] slot_cond,
    input  logic [rob_pkg::group_size*rob_pkg::pc_w-1:0]   slot_pc,
    input  logic [rob_pkg::group_size*rob_pkg::preg_w-1:0] slot_preg,
    input  logic [idx_w:0]                                 tail,
    input  logic                                           full_stll,
    input  logic                                           mis_pred,
    input  logic                                           done_vld_0,
    input  logic                                           done_vld_1,
    input  logic                                           done_vld_2,
    input  logic                                           done_vld_3,
    input  logic [idx_w-1:0]                               done_idx_0,
    input  logic [idx_w-1:0]                               done_idx_1,
    input  logic [idx_w-1:0]                               done_idx_2,
    input  logic [idx_w-1:0]                               done_idx_3,
    input  logic [idx_w-1:0]                               brnc_idx,
    input  logic                                           cmt_brnc,
    input  logic [idx_w-1:0]                               mis_pred_idx,
    input  logic [idx_w:0]                                 head,
    input  logic [rob_pkg::cnt_w-1:0]                      cmt_cnt,
    output logic [rob_pkg::commit_width-1:0]               win_vld,
    output logic [rob_pkg::commit_width-1:0]               win_done,
    output logic [rob_pkg::commit_width-1:0]               win_reg_wrt,
    output logic [rob_pkg::commit_width*rob_pkg::preg_w-1:0] win_preg,
    output logic                                           br_is_brnc,
    output logic                                           br_pred,
    output logic [rob_pkg::cond_w-1:0]                     br_cond,
    output logic [rob_pkg::pc_w-1:0]                       br_pc
);
    import rob_pkg::*;

    logic [rob_depth-1:0] vld;
    logic [rob_depth-1:0] done;
    logic [rob_depth-1:0] brnc;
    logic [rob_depth-1:0] pred;
    logic [rob_depth-1:0] reg_wrt;
    logic [cond_w-1:0]    cond [rob_depth];
    logic [pc_w-1:0]      pc   [rob_depth];
    logic [preg_w-1:0]    preg [rob_depth];

    // per-entry decode of this cycle's events
    logic [rob_depth-1:0] wr_en;
    logic [1:0]           wr_slot [rob_depth];
    logic [rob_depth-1:0] cmt_clr;
    logic [rob_depth-1:0] bubble;
    logic [rob_depth-1:0] kill;
    logic [rob_depth-1:0] done_set;

    logic [n_done_ports-1:0] dv;
    logic [idx_w-1:0]        di [n_done_ports];
    logic                    alloc_ok;
    logic [idx_w-1:0]        bnd;
    logic [idx_w-1:0]        kill_span;

    assign dv = {done_vld_3, done_vld_2, done_vld_1, done_vld_0};
    assign di[0] = done_idx_0;
    assign di[1] = done_idx_1;
    assign di[2] = done_idx_2;
    assign di[3] = done_idx_3;

    assign alloc_ok = alloc && !full_stll && !mis_pred;

    // later groups run from the boundary after the branch up to the old tail
    assign bnd = {mis_pred_idx[idx_w-1:2] + 1'b1, 2'b00};
    assign kill_span = tail[idx_w-1:0] - bnd;

    always_comb begin
        logic [idx_w-1:0] e;
        logic [idx_w-1:0] off_t;
        logic [idx_w-1:0] off_h;
        for (int i = 0; i < rob_depth; i++) begin
            e = idx_w'(i);
            off_t = e - tail[idx_w-1:0];
            off_h = e - head[idx_w-1:0];
            wr_en[i] = alloc_ok && (off_t < idx_w'(group_size));
            wr_slot[i] = off_t[1:0];
            cmt_clr[i] = off_h < idx_w'(cmt_cnt);
            // younger slots sharing the branch's group
            bubble[i] = mis_pred && (e[idx_w-1:2] == mis_pred_idx[idx_w-1:2])
                        && (e[1:0] > mis_pred_idx[1:0]);
            kill[i] = mis_pred && ((e - bnd) < kill_span);
            // a resolved branch is done whichever way it went
            done_set[i] = (cmt_brnc || mis_pred) && (brnc_idx == e);
            for (int d = 0; d < n_done_ports; d++) begin
                done_set[i] = done_set[i] | (dv[d] && (di[d] == e));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld  <= '0;
            done <= '0;
        end else begin
            for (int i = 0; i < rob_depth; i++) begin
                if (kill[i]) begin
                    vld[i] <= 1'b0;
                end else if (wr_en[i]) begin
                    // empty slots enter as finished bubbles
                    vld[i]  <= 1'b1;
                    done[i] <= !slot_vld[wr_slot[i]];
                end else if (bubble[i]) begin
                    done[i] <= 1'b1;
                end else begin
                    if (cmt_clr[i]) begin
                        vld[i] <= 1'b0;
                    end
                    if (done_set[i]) begin
                        done[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rob_depth; i++) begin
            if (wr_en[i]) begin
                brnc[i]    <= slot_vld[wr_slot[i]] && slot_brnc[wr_slot[i]];
                reg_wrt[i] <= slot_vld[wr_slot[i]] && slot_reg_wrt[wr_slot[i]];
                pred[i]    <= slot_pred[wr_slot[i]];
                cond[i]    <= slot_cond[wr_slot[i]*cond_w +: cond_w];
                pc[i]      <= slot_pc[wr_slot[i]*pc_w +: pc_w];
                preg[i]    <= slot_preg[wr_slot[i]*preg_w +: preg_w];
            end else if (bubble[i]) begin
                // a bubble frees nothing and cannot resolve
                brnc[i]    <= 1'b0;
                reg_wrt[i] <= 1'b0;
            end
        end
    end

    // oldest entries, starting at the head
    always_comb begin
        logic [idx_w-1:0] h;
        for (int w = 0; w < commit_width; w++) begin
            h = head[idx_w-1:0] + idx_w'(w);
            win_vld[w] = vld[h];
            win_done[w] = done[h];
            win_reg_wrt[w] = reg_wrt[h];
            win_preg[w*preg_w +: preg_w] = preg[h];
        end
    end

    assign br_is_brnc = vld[brnc_idx] && brnc[brnc_idx];
    assign br_pred = pred[brnc_idx];
    assign br_cond = cond[brnc_idx];
    assign br_pc = pc[brnc_idx];

endmodule

// File: source/rob_branch_resolve.sv
`timescale 1ns/1ps

module rob_branch_resolve #(
    parameter int rob_depth = rob_pkg::default_depth,
    localparam int idx_w = $clog2(rob_depth)
) (
    input  logic [rob_pkg::cmp_w-1:0]  brnc_cmp_rslt,
    input  logic [idx_w-1:0]           brnc_idx,
    input  logic                       br_is_brnc,
    input  logic                       br_pred,
    input  logic [rob_pkg::cond_w-1:0] br_cond,
    input  logic [rob_pkg::pc_w-1:0]   br_pc,
    output logic                       mis_pred,
    output logic [idx_w-1:0]           mis_pred_idx,
    output logic                       cmt_brnc,
    output logic [rob_pkg::pc_w-1:0]   rcvr_pc_out,
    output logic                       brnc_pred_log
);
    import rob_pkg::*;

    logic resolving;
    logic taken;

    // a result only counts against a live branch entry
    assign resolving = (brnc_cmp_rslt != '0) && br_is_brnc;

    // taken when the stored condition matches the compare result
    assign taken = (br_cond == cond_w'(brnc_cmp_rslt));

    assign mis_pred = resolving && (br_pred != taken);
    assign cmt_brnc = resolving && (br_pred == taken);

    assign mis_pred_idx = mis_pred ? brnc_idx : '0;

    // prediction that was logged, for predictor training
    assign brnc_pred_log = resolving && br_pred;

    assign rcvr_pc_out = resolving ? br_pc : '0;

endmodule

// File: source/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
    input  logic [rob_pkg::commit_width-1:0]                 win_vld,
    input  logic [rob_pkg::commit_width-1:0]                 win_done,
    input  logic [rob_pkg::commit_width-1:0]                 win_reg_wrt,
    input  logic [rob_pkg::commit_width*rob_pkg::preg_w-1:0] win_preg,
    output logic [rob_pkg::cnt_w-1:0]                        cmt_cnt,
    output logic [rob_pkg::cnt_w-1:0]                        free_preg_cnt,
    output logic [rob_pkg::preg_w-1:0]                       free_preg_num1,
    output logic [rob_pkg::preg_w-1:0]                       free_preg_num2,
    output logic [rob_pkg::preg_w-1:0]                       free_preg_num3,
    output logic [rob_pkg::preg_w-1:0]                       free_preg_num4
);
    import rob_pkg::*;

    // set for every entry inside the leading valid and done run
    logic [commit_width-1:0] run;
    logic [preg_w-1:0]       num [commit_width];

    always_comb begin
        run[0] = win_vld[0] && win_done[0];
        for (int w = 1; w < commit_width; w++) begin
            run[w] = run[w-1] && win_vld[w] && win_done[w];
        end
    end

    // pack freed registers oldest first, leaving the rest at zero
    always_comb begin
        cmt_cnt = '0;
        free_preg_cnt = '0;
        for (int k = 0; k < commit_width; k++) begin
            num[k] = '0;
        end
        for (int w = 0; w < commit_width; w++) begin
            if (run[w]) begin
                cmt_cnt = cmt_cnt + 1'b1;
                if (win_reg_wrt[w]) begin
                    num[free_preg_cnt[1:0]] = win_preg[w*preg_w +: preg_w];
                    free_preg_cnt = free_preg_cnt + 1'b1;
                end
            end
        end
    end

    assign free_preg_num1 = num[0];
    assign free_preg_num2 = num[1];
    assign free_preg_num3 = num[2];
    assign free_preg_num4 = num[3];

endmodule

// File: source/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
    parameter int rob_depth = rob_pkg::default_depth,
    localparam int idx_w = $clog2(rob_depth)
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           alloc,
    input  logic [rob_pkg::group_size-1:0]                 slot_vld,
    input  logic [rob_pkg::group_size-1:0]                 slot_reg_wrt,
    input  logic [rob_pkg::group_size-1:0]                 slot_brnc,
    input  logic [rob_pkg::group_size-1:0]                 slot_pred,
    input  logic [rob_pkg::group_size*rob_pkg::cond_w-1:0] slot_cond,
    input  logic [rob_pkg::group_size*rob_pkg::pc_w-1:0]   slot_pc,
    input  logic [rob_pkg::group_size*rob_pkg::preg_w-1:0] slot_preg,
    input  logic                                           done_vld_0,
    input  logic                                           done_vld_1,
    input  logic                                           done_vld_2,
    input  logic                                           done_vld_3,
    input  logic [idx_w-1:0]                               done_idx_0,
    input  logic [idx_w-1:0]                               done_idx_1,
    input  logic [idx_w-1:0]                               done_idx_2,
    input  logic [idx_w-1:0]                               done_idx_3,
    input  logic [idx_w-1:0]                               brnc_idx,
    input  logic [rob_pkg::cmp_w-1:0]                      brnc_cmp_rslt,
    output logic [idx_w:0]                                 next_idx,
    output logic                                           full_stll,
    output logic                                           empt,
    output logic                                           mis_pred,
    output logic [idx_w-1:0]                               mis_pred_idx,
    output logic                                           cmt_brnc,
    output logic                                           brnc_pred_log,
    output logic [rob_pkg::pc_w-1:0]                       rcvr_pc_out,
    output logic [rob_pkg::cnt_w-1:0]                      cmt_cnt,
    output logic [rob_pkg::cnt_w-1:0]                      free_preg_cnt,
    output logic [rob_pkg::preg_w-1:0]                     free_preg_num1,
    output logic [rob_pkg::preg_w-1:0]                     free_preg_num2,
    output logic [rob_pkg::preg_w-1:0]                     free_preg_num3,
    output logic [rob_pkg::preg_w-1:0]                     free_preg_num4
);
    import rob_pkg::*;

    logic [idx_w:0]               head;
    logic [idx_w:0]               tail;

    // oldest entries, as seen by the commit logic
    logic [commit_width-1:0]        win_vld;
    logic [commit_width-1:0]        win_done;
    logic [commit_width-1:0]        win_reg_wrt;
    logic [commit_width*preg_w-1:0] win_preg;

    // entry addressed by the branch result
    logic                         br_is_brnc;
    logic                         br_pred;
    logic [cond_w-1:0]            br_cond;
    logic [pc_w-1:0]              br_pc;

    // submodule ports share their names with the nets above
    rob_pointers #(.rob_depth(rob_depth)) u_pointers (.*);

    rob_entry_array #(.rob_depth(rob_depth)) u_entry_array (.*);

    rob_branch_resolve #(.rob_depth(rob_depth)) u_branch_resolve (.*);

    rob_commit u_commit (.*);

endmodule

// File: tb/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    localparam int depth = default_depth;
    localparam int fill_cycles = 20;
    localparam int rand_cycles = 400;
    localparam int drain_cycles = 2 * depth;
    // twice the longest expected run
    localparam int max_cycles = 2 * (5 + fill_cycles + rand_cycles + drain_cycles);

    logic clk = 0;
    logic rst_n = 0;
    logic alloc = 0;
    logic [3:0] slot_vld = 0, slot_reg_wrt = 0, slot_brnc = 0, slot_pred = 0;
    logic [7:0] slot_cond = 0;
    logic [63:0] slot_pc = 0;
    logic [23:0] slot_preg = 0;
    logic done_vld_0 = 0, done_vld_1 = 0, done_vld_2 = 0, done_vld_3 = 0;
    logic [5:0] done_idx_0 = 0, done_idx_1 = 0, done_idx_2 = 0, done_idx_3 = 0;
    logic [5:0] brnc_idx = 0;
    logic [1:0] brnc_cmp_rslt = 0;
    logic [6:0] next_idx;
    logic full_stll, empt, mis_pred, cmt_brnc, brnc_pred_log;
    logic [5:0] mis_pred_idx;
    logic [15:0] rcvr_pc_out;
    logic [2:0] cmt_cnt, free_preg_cnt;
    logic [5:0] free_preg_num1, free_preg_num2, free_preg_num3, free_preg_num4;

    rob_top #(.rob_depth(depth)) u_dut (.*);

    always #20 clk = ~clk;

    // reference model state
    logic m_vld [depth], m_done [depth], m_brnc [depth], m_pred [depth], m_regw [depth];
    logic [1:0] m_cond [depth];
    logic [15:0] m_pc [depth];
    logic [5:0] m_preg [depth];
    logic [6:0] m_head, m_tail;

    logic exp_full, exp_empt, exp_mis, exp_cmt_brnc, exp_log;
    logic [5:0] exp_midx;
    logic [15:0] exp_pc;
    logic [2:0] exp_cnt, exp_fcnt;
    logic [5:0] exp_num [4];

    int errors = 0;
    int cycles = 0;
    int unsigned lcg_state = 59;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    task automatic report_mismatch(string name, longint got, longint expv);
        errors++;
        $display("ERROR %0t %s got %0h expected %0h", $time, name, got, expv);
    endtask

    // expected outputs from model state and present inputs
    always_comb begin
        logic [6:0] occ;
        logic [5:0] h;
        logic run;
        logic res;
        logic taken;
        occ = m_tail - m_head;
        exp_full = int'(occ) > depth - group_size;
        exp_empt = (occ == 0);
        exp_cnt = 0;
        exp_fcnt = 0;
        run = 1;
        for (int k = 0; k < 4; k++) begin
            exp_num[k] = 0;
        end
        for (int w = 0; w < 4; w++) begin
            h = m_head[5:0] + 6'(w);
            run = run && m_vld[h] && m_done[h];
            if (run) begin
                exp_cnt = exp_cnt + 3'd1;
                if (m_regw[h]) begin
                    exp_num[exp_fcnt[1:0]] = m_preg[h];
                    exp_fcnt = exp_fcnt + 3'd1;
                end
            end
        end
        res = (brnc_cmp_rslt != 0) && m_vld[brnc_idx] && m_brnc[brnc_idx];
        taken = (m_cond[brnc_idx] == brnc_cmp_rslt);
        exp_mis = res && (m_pred[brnc_idx] != taken);
        exp_cmt_brnc = res && (m_pred[brnc_idx] == taken);
        exp_log = res && m_pred[brnc_idx];
        exp_pc = res ? m_pc[brnc_idx] : 16'd0;
        exp_midx = exp_mis ? brnc_idx : 6'd0;
    end

    always @(posedge clk or negedge rst_n) begin
        logic [2:0] c;
        logic m;
        logic a;
        logic ds;
        logic [5:0] mi, bnd, span, e, off, s;
        logic [6:0] h, t, bp;
        if (!rst_n) begin
            m_head = 0;
            m_tail = 0;
            for (int i = 0; i < depth; i++) begin
                m_vld[i] = 0;
                m_done[i] = 0;
                m_brnc[i] = 0;
                m_pred[i] = 0;
                m_regw[i] = 0;
                m_cond[i] = 0;
                m_pc[i] = 0;
                m_preg[i] = 0;
            end
        end else begin
            c = exp_cnt;
            m = exp_mis;
            mi = brnc_idx;
            h = m_head;
            t = m_tail;
            a = alloc && !exp_full && !m;
            bp = h + {1'b0, 6'(mi - h[5:0])};
            bnd = {mi[5:2] + 4'd1, 2'b00};
            span = t[5:0] - bnd;
            for (int i = 0; i < depth; i++) begin
                e = 6'(i);
                off = e - bnd;
                s = e - t[5:0];
                if (m && off < span) begin
                    m_vld[i] = 0;
                end else if (a && s < 6'd4) begin
                    m_vld[i] = 1;
                    m_done[i] = !slot_vld[s[1:0]];
                    m_brnc[i] = slot_vld[s[1:0]] && slot_brnc[s[1:0]];
                    m_regw[i] = slot_vld[s[1:0]] && slot_reg_wrt[s[1:0]];
                    m_pred[i] = slot_pred[s[1:0]];
                    m_cond[i] = slot_cond[s[1:0]*2 +: 2];
                    m_pc[i] = slot_pc[s[1:0]*16 +: 16];
                    m_preg[i] = slot_preg[s[1:0]*6 +: 6];
                end else if (m && e[5:2] == mi[5:2] && e[1:0] > mi[1:0]) begin
                    // younger slot in the branch's group
                    m_done[i] = 1;
                    m_brnc[i] = 0;
                    m_regw[i] = 0;
                end else begin
                    off = e - h[5:0];
                    if (off < 6'(c)) begin
                        m_vld[i] = 0;
                    end
                    ds = (exp_cmt_brnc || m) && brnc_idx == e;
                    ds = ds || (done_vld_0 && done_idx_0 == e) || (done_vld_1 && done_idx_1 == e);
                    ds = ds || (done_vld_2 && done_idx_2 == e) || (done_vld_3 && done_idx_3 == e);
                    if (ds) begin
                        m_done[i] = 1;
                    end
                end
            end
            m_head = h + 7'(c);
            if (m) begin
                m_tail = {bp[6:2] + 5'd1, 2'b00};
            end else if (a) begin
                m_tail = t + 7'd4;
            end
        end
    end

    // outputs are stable at the falling edge
    a_next: assert property (@(negedge clk) disable iff (!rst_n) next_idx == m_tail)
        else report_mismatch("next_idx", next_idx, m_tail);
    a_full: assert property (@(negedge clk) disable iff (!rst_n) full_stll == exp_full)
        else report_mismatch("full_stll", full_stll, exp_full);
    a_empt: assert property (@(negedge clk) disable iff (!rst_n) empt == exp_empt)
        else report_mismatch("empt", empt, exp_empt);
    a_cnt: assert property (@(negedge clk) disable iff (!rst_n) cmt_cnt == exp_cnt)
        else report_mismatch("cmt_cnt", cmt_cnt, exp_cnt);
    a_fcnt: assert property (@(negedge clk) disable iff (!rst_n) free_preg_cnt == exp_fcnt)
        else report_mismatch("free_preg_cnt", free_preg_cnt, exp_fcnt);
    a_num1: assert property (@(negedge clk) disable iff (!rst_n) free_preg_num1 == exp_num[0])
        else report_mismatch("free_preg_num1", free_preg_num1, exp_num[0]);
    a_num2: assert property (@(negedge clk) disable iff (!rst_n) free_preg_num2 == exp_num[1])
        else report_mismatch("free_preg_num2", free_preg_num2, exp_num[1]);
    a_num3: assert property (@(negedge clk) disable iff (!rst_n) free_preg_num3 == exp_num[2])
        else report_mismatch("free_preg_num3", free_preg_num3, exp_num[2]);
    a_num4: assert property (@(negedge clk) disable iff (!rst_n) free_preg_num4 == exp_num[3])
        else report_mismatch("free_preg_num4", free_preg_num4, exp_num[3]);
    a_mis: assert property (@(negedge clk) disable iff (!rst_n) mis_pred == exp_mis)
        else report_mismatch("mis_pred", mis_pred, exp_mis);
    a_midx: assert property (@(negedge clk) disable iff (!rst_n) mis_pred_idx == exp_midx)
        else report_mismatch("mis_pred_idx", mis_pred_idx, exp_midx);
    a_cbr: assert property (@(negedge clk) disable iff (!rst_n) cmt_brnc == exp_cmt_brnc)
        else report_mismatch("cmt_brnc", cmt_brnc, exp_cmt_brnc);
    a_log: assert property (@(negedge clk) disable iff (!rst_n) brnc_pred_log == exp_log)
        else report_mismatch("brnc_pred_log", brnc_pred_log, exp_log);
    a_pc: assert property (@(negedge clk) disable iff (!rst_n) rcvr_pc_out == exp_pc)
        else report_mismatch("rcvr_pc_out", rcvr_pc_out, exp_pc);

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles, the buffer never drained", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic fill_slots();
        for (int s = 0; s < 4; s++) begin
            slot_vld[s] = (lcg_next() % 4) != 0;
            slot_reg_wrt[s] = (lcg_next() % 2) != 0;
            slot_brnc[s] = (lcg_next() % 3) == 0;
            slot_pred[s] = (lcg_next() % 2) != 0;
            slot_cond[s*2 +: 2] = 2'(lcg_next());
            slot_pc[s*16 +: 16] = 16'(lcg_next());
            slot_preg[s*6 +: 6] = 6'(lcg_next());
        end
    endtask

    // random completions among live entries
    task automatic pick_done(output logic v, output logic [5:0] idx);
        int occ;
        occ = int'(7'(m_tail - m_head));
        v = (occ > 0) && (lcg_next() % 4 != 0);
        idx = m_head[5:0] + 6'(occ > 0 ? lcg_next() % occ : 0);
    endtask

    // resolve only a live branch that is still pending
    task automatic pick_branch();
        int occ;
        int start;
        logic [5:0] e;
        occ = int'(7'(m_tail - m_head));
        brnc_cmp_rslt = 0;
        if (occ > 0 && lcg_next() % 2 == 0) begin
            start = lcg_next() % occ;
            for (int k = 0; k < occ; k++) begin
                e = m_head[5:0] + 6'((start + k) % occ);
                if (brnc_cmp_rslt == 0 && m_vld[e] && m_brnc[e] && !m_done[e]) begin
                    brnc_idx = e;
                    brnc_cmp_rslt = 2'(1 + lcg_next() % 3);
                end
            end
        end
    endtask

    initial begin
        logic [5:0] nxt;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1;
        @(negedge clk);
        // inactive values straight out of reset
        assert (empt == 1'b1)
            else report_mismatch("empt", empt, 1);
        assert (next_idx == 0)
            else report_mismatch("next_idx", next_idx, 0);
        assert (full_stll == 1'b0)
            else report_mismatch("full_stll", full_stll, 0);
        assert (mis_pred == 1'b0)
            else report_mismatch("mis_pred", mis_pred, 0);
        assert (cmt_brnc == 1'b0)
            else report_mismatch("cmt_brnc", cmt_brnc, 0);
        assert (cmt_cnt == 0)
            else report_mismatch("cmt_cnt", cmt_cnt, 0);
        assert (free_preg_cnt == 0)
            else report_mismatch("free_preg_cnt", free_preg_cnt, 0);
        // fill past full with no completions
        for (int n = 0; n < fill_cycles; n++) begin
            @(posedge clk);
            #2;
            alloc = 1;
            fill_slots();
        end
        for (int n = 0; n < rand_cycles; n++) begin
            @(posedge clk);
            #2;
            alloc = (lcg_next() % 2) != 0;
            fill_slots();
            pick_done(done_vld_0, done_idx_0);
            pick_done(done_vld_1, done_idx_1);
            pick_done(done_vld_2, done_idx_2);
            pick_done(done_vld_3, done_idx_3);
            pick_branch();
        end
        // drain by completing the oldest entries in order
        @(posedge clk);
        #2;
        alloc = 0;
        brnc_cmp_rslt = 0;
        while (!empt) begin
            nxt = m_head[5:0];
            done_vld_0 = 1;
            done_vld_1 = 1;
            done_vld_2 = 1;
            done_vld_3 = 1;
            done_idx_0 = nxt;
            done_idx_1 = nxt + 6'd1;
            done_idx_2 = nxt + 6'd2;
            done_idx_3 = nxt + 6'd3;
            @(posedge clk);
            #2;
        end
        done_vld_0 = 0;
        done_vld_1 = 0;
        done_vld_2 = 0;
        done_vld_3 = 0;
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: rob.f
source/rob_pkg.sv
source/rob_pointers.sv
source/rob_entry_array.sv
source/rob_branch_resolve.sv
source/rob_commit.sv
source/rob_top.sv
tb/rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= rob.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
